// File: flist.f
src/kitchen_pkg.sv
src/button_sync.sv
src/debounce.sv
src/player_mover.sv
src/seven_seg_controller.sv
src/player_panel_top.sv
sim/player_panel_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the player panel testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
   echo "verilator not found on PATH"
   exit 1
fi

if ! verilator --binary --timing --assert \
      --top-module player_panel_tb \
      -Mdir obj_dir \
      -f flist.f; then
   echo "build failed"
   exit 1
fi

output=$(./obj_dir/Vplayer_panel_tb 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
   exit 0
fi

echo "pass message not found"
exit 1

// File: sim/player_panel_tb.sv
`timescale 1ns/1ps

module player_panel_tb;

   // one row of the step table
   typedef struct packed {
      kitchen_pkg::button_vec_t pattern;
      logic                     carry;
      int                       glitches;   // toggles before settling
      logic                     hold;       // 0 means glitch train only
      kitchen_pkg::grid_coord_t exp_x;
      kitchen_pkg::grid_coord_t exp_y;
      kitchen_pkg::direction_t  exp_dir;
      kitchen_pkg::chop_count_t exp_chop;
   } step_t;

   // g..a, high means lit
   localparam logic [6:0] seg_table [16] = '{
      7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
      7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
   };

   logic                     clk_in;
   logic                     reset_in;
   kitchen_pkg::button_vec_t btn_raw;
   logic                     carry_raw;
   kitchen_pkg::grid_coord_t player_x;
   kitchen_pkg::grid_coord_t player_y;
   kitchen_pkg::direction_t  direction;
   kitchen_pkg::chop_count_t chop_count;
   logic [6:0]               cat_out;
   logic [7:0]               an_out;

   step_t steps[$];
   string step_names[$];
   int    cycle_count;
   int    timeout_cycles;

   player_panel_top #(
      .debounce_cycles (8),
      .scan_cycles     (3)
   ) dut0 (
      .clk_in     (clk_in),
      .reset_in   (reset_in),
      .btn_raw    (btn_raw),
      .carry_raw  (carry_raw),
      .player_x   (player_x),
      .player_y   (player_y),
      .direction  (direction),
      .chop_count (chop_count),
      .cat_out    (cat_out),
      .an_out     (an_out)
   );

   initial begin
      clk_in = 1'b0;
      forever #10 clk_in = ~clk_in;   // 20 ns period
   end

   // watchdog
   always @(posedge clk_in) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > timeout_cycles) begin
         $display("timeout: the run went past %0d clocks without finishing", timeout_cycles);
         $display("tests failed");
         $fatal(1, "watchdog expired");
      end
   end

   ////////////////////
   // helpers
   ////////////////////

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         $display("Mismatch %s expected %0h actual %0h", name, expected, actual);
         $display("tests failed");
         $fatal(1, "value check failed");
      end
   endtask

   task automatic wait_clocks(input int n);
      repeat (n) @(negedge clk_in);
   endtask

   function automatic kitchen_pkg::button_vec_t one_button(input int idx);
      return kitchen_pkg::button_vec_t'(1 << idx);
   endfunction

   task automatic add_step(input string name, input kitchen_pkg::button_vec_t pattern,
                           input logic carry, input int glitches, input logic hold,
                           input int ex, input int ey, input kitchen_pkg::direction_t ed,
                           input int ec);
      step_t rec;
      rec.pattern  = pattern;
      rec.carry    = carry;
      rec.glitches = glitches;
      rec.hold     = hold;
      rec.exp_x    = kitchen_pkg::grid_coord_t'(ex);
      rec.exp_y    = kitchen_pkg::grid_coord_t'(ey);
      rec.exp_dir  = ed;
      rec.exp_chop = kitchen_pkg::chop_count_t'(ec);
      steps.push_back(rec);
      step_names.push_back(name);
   endtask

   task automatic check_outputs(input string name, input step_t st);
      check_value({name, " x"}, 32'(st.exp_x), 32'(player_x));
      check_value({name, " y"}, 32'(st.exp_y), 32'(player_y));
      check_value({name, " direction"}, 32'(st.exp_dir), 32'(direction));
      check_value({name, " chops"}, 32'(st.exp_chop), 32'(chop_count));
   endtask

   // one full scan of all eight digits, 32 clocks
   task automatic check_display(input string name, input step_t st);
      logic [31:0] exp_word;
      logic [7:0]  seen;
      logic [6:0]  exp_seg;
      logic [3:0]  nib;
      int          lit;
      int          k;
      exp_word = {st.exp_chop, 4'h0, 2'b00, st.exp_dir, st.exp_x, st.exp_y};
      seen = '0;
      for (int c = 0; c < 8 * (3 + 1); c++) begin
         @(negedge clk_in);
         lit = 0;
         k = 0;
         for (int d = 0; d < 8; d++) begin
            if (!an_out[d]) begin
               lit = lit + 1;
               k = d;
            end
         end
         check_value({name, " digits lit"}, 32'd1, 32'(lit));
         nib = exp_word[k*4 +: 4];
         exp_seg = ~seg_table[nib];   // common anode
         check_value($sformatf("%s digit %0d", name, k), 32'(exp_seg), 32'(cat_out));
         seen[k] = 1'b1;
      end
      check_value({name, " digits seen"}, 32'hff, 32'(seen));
   endtask

   ////////////////////
   // step table
   ////////////////////

   task automatic load_steps;
      kitchen_pkg::button_vec_t up;
      kitchen_pkg::button_vec_t down;
      kitchen_pkg::button_vec_t left;
      kitchen_pkg::button_vec_t right;
      kitchen_pkg::button_vec_t chop;
      up    = one_button(kitchen_pkg::btn_up);
      down  = one_button(kitchen_pkg::btn_down);
      left  = one_button(kitchen_pkg::btn_left);
      right = one_button(kitchen_pkg::btn_right);
      chop  = one_button(kitchen_pkg::btn_chop);
      // facing changes even against a wall
      add_step("up_clamp", up, 1'b0, 1, 1'b1, 0, 0, kitchen_pkg::facing_up, 0);
      add_step("left_clamp", left, 1'b0, 2, 1'b1, 0, 0, kitchen_pkg::facing_left, 0);
      for (int i = 1; i <= 13; i++) begin   // last one hits the right wall
         add_step($sformatf("right_%0d", i), right, 1'b0, i % 4, 1'b1,
                  (i < 12) ? i : 12, 0, kitchen_pkg::facing_right, 0);
      end
      for (int i = 1; i <= 8; i++) begin
         add_step($sformatf("down_%0d", i), down, 1'b0, i % 4, 1'b1,
                  12, (i < 7) ? i : 7, kitchen_pkg::facing_down, 0);
      end
      add_step("glitch_left", left, 1'b0, 4, 1'b0, 12, 7, kitchen_pkg::facing_down, 0);
      for (int i = 1; i <= 3; i++) begin
         add_step($sformatf("chop_%0d", i), chop, 1'b0, i % 4, 1'b1,
                  12, 7, kitchen_pkg::facing_down, i);
      end
      for (int i = 1; i <= 2; i++) begin   // hands full
         add_step($sformatf("chop_carry_%0d", i), chop, 1'b1, i, 1'b1,
                  12, 7, kitchen_pkg::facing_down, 3);
      end
      add_step("chop_after_carry", chop, 1'b0, 1, 1'b1, 12, 7, kitchen_pkg::facing_down, 4);
      for (int i = 1; i <= 13; i++) begin
         add_step($sformatf("left_%0d", i), left, 1'b0, i % 4, 1'b1,
                  (i < 12) ? 12 - i : 0, 7, kitchen_pkg::facing_left, 4);
      end
      for (int i = 1; i <= 8; i++) begin
         add_step($sformatf("up_%0d", i), up, 1'b0, i % 4, 1'b1,
                  0, (i < 7) ? 7 - i : 0, kitchen_pkg::facing_up, 4);
      end
      add_step("glitch_chop", chop, 1'b0, 4, 1'b0, 0, 0, kitchen_pkg::facing_up, 4);
   endtask

   ////////////////////
   // main sequence
   ////////////////////

   initial begin
      step_t st;
      step_t reset_state;
      reset_in    = 1'b1;
      btn_raw     = '0;
      carry_raw   = 1'b0;
      cycle_count = 0;
      void'($urandom(32'hbed74c52));
      load_steps();
      timeout_cycles = steps.size() * 80 + 200;

      wait_clocks(5);
      reset_in = 1'b0;
      reset_state = '0;   // origin, facing up, no chops
      check_outputs("reset", reset_state);
      check_display("reset", reset_state);

      for (int s = 0; s < steps.size(); s++) begin
         st = steps[s];
         carry_raw = st.carry;
         for (int g = 0; g < st.glitches; g++) begin
            btn_raw = (g % 2 == 0) ? st.pattern : '0;
            wait_clocks($urandom % 4 + 1);   // well under the hold time
         end
         btn_raw = st.hold ? st.pattern : '0;
         wait_clocks(30);
         check_outputs(step_names[s], st);
         btn_raw = '0;
         check_display(step_names[s], st);   // covers the release wait
      end

      $display("all tests passed");
      $finish;
   end

endmodule

// File: src/button_sync.sv
`timescale 1ns/1ps

module button_sync (
   input  logic                     clk_in,
   input  logic                     reset_in,
   input  kitchen_pkg::button_vec_t btn_raw,
   input  logic                     carry_raw,
   output kitchen_pkg::button_vec_t btn_sync,
   output logic                     carry_sync
);

   // carry rides along as the top bit
   localparam int sync_w = kitchen_pkg::num_buttons + 1;

   logic [sync_w-1:0] raw_bundle;
   logic [sync_w-1:0] stage1;   // may go metastable
   logic [sync_w-1:0] stage2;   // settled copy

   assign raw_bundle = {carry_raw, btn_raw};

   ////////////////////
   // two flop chain
   ////////////////////

   always_ff @(posedge clk_in) begin
      if (reset_in) begin
         stage1 <= '0;
         stage2 <= '0;
      end else begin
         stage1 <= raw_bundle;
         stage2 <= stage1;
      end
   end

   assign btn_sync   = stage2[kitchen_pkg::num_buttons-1:0];
   assign carry_sync = stage2[sync_w-1];

endmodule

// File: src/debounce.sv
`timescale 1ns/1ps

module debounce #(
   parameter int debounce_cycles = kitchen_pkg::default_debounce_cycles
) (
   input  logic clk_in,
   input  logic reset_in,
   input  logic noisy,
   output logic clean
);

   // wide enough to hold the limit itself
   localparam int cnt_w = (debounce_cycles < 1) ? 1 : $clog2(debounce_cycles + 1);
   localparam logic [cnt_w-1:0] limit = cnt_w'(debounce_cycles);

   logic [cnt_w-1:0] count;    // clocks the sample has been stable
   logic             sample;   // last level seen on noisy

   ////////////////////
   // stability counter
   ////////////////////

   always_ff @(posedge clk_in) begin
      if (reset_in) begin
         sample <= noisy;      // start out agreeing with the pin
         clean  <= noisy;
         count  <= '0;
      end else if (noisy != sample) begin
         sample <= noisy;      // any bounce starts over
         count  <= '0;
      end else if (count == limit) begin
         clean <= sample;      // held long enough
      end else begin
         count <= count + 1'b1;
      end
   end

   // clean moves only off a full quiet period
   clean_on_limit_a : assert property (
      @(posedge clk_in) disable iff (reset_in)
      $changed(clean) |-> $past(count == limit) || $past(reset_in)
   );

endmodule

// File: src/kitchen_pkg.sv
package kitchen_pkg;

   ////////////////////
   // button map
   ////////////////////

   localparam int num_buttons = 5;

   // bit index of each button in the button vectors
   localparam int btn_up    = 0;
   localparam int btn_down  = 1;
   localparam int btn_left  = 2;
   localparam int btn_right = 3;
   localparam int btn_chop  = 4;

   ////////////////////
   // kitchen grid
   ////////////////////

   localparam int grid_cols = 13; // x in 0..12
   localparam int grid_rows = 8;  // y in 0..7

   ////////////////////
   // timing defaults
   ////////////////////

   // hardware values, sim overrides these at the top
   localparam int default_debounce_cycles = 1_000_000;
   localparam int default_scan_cycles     = 100_000;   // clocks per digit

   ////////////////////
   // types
   ////////////////////

   typedef logic [num_buttons-1:0] button_vec_t; // one bit per button

   typedef logic [7:0] grid_coord_t;  // player x or y
   typedef logic [7:0] chop_count_t;  // wraps at 256
   typedef logic [31:0] status_word_t; // eight hex digits for the display

   // facing of the player, shown as digit 4
   typedef enum logic [1:0] {
      facing_up    = 2'd0,
      facing_down  = 2'd1,
      facing_left  = 2'd2,
      facing_right = 2'd3
   } direction_t;

endpackage

// File: src/player_mover.sv
`timescale 1ns/1ps

module player_mover (
   input  logic                      clk_in,
   input  logic                      reset_in,
   input  kitchen_pkg::button_vec_t  btn_clean,
   input  logic                      carry,
   output kitchen_pkg::grid_coord_t  player_x,
   output kitchen_pkg::grid_coord_t  player_y,
   output kitchen_pkg::direction_t   direction,
   output kitchen_pkg::chop_count_t  chop_count,
   output kitchen_pkg::status_word_t status_word
);

   // last legal cell on each axis
   localparam kitchen_pkg::grid_coord_t max_x = kitchen_pkg::grid_coord_t'(kitchen_pkg::grid_cols - 1);
   localparam kitchen_pkg::grid_coord_t max_y = kitchen_pkg::grid_coord_t'(kitchen_pkg::grid_rows - 1);

   kitchen_pkg::button_vec_t btn_prev;   // clean levels one clock back
   kitchen_pkg::button_vec_t rise;       // fresh presses this clock
   kitchen_pkg::button_vec_t rise_q;     // presses acted on next clock

   ////////////////////
   // press detection
   ////////////////////

   assign rise = btn_clean & ~btn_prev;

   always_ff @(posedge clk_in) begin
      if (reset_in) begin
         btn_prev <= btn_clean;   // a button held through reset is not a press
         rise_q   <= '0;
      end else begin
         btn_prev <= btn_clean;
         rise_q   <= rise;
      end
   end

   ////////////////////
   // player state
   ////////////////////

   // one action per clock, up has the highest priority and chop the lowest
   always_ff @(posedge clk_in) begin
      if (reset_in) begin
         player_x   <= '0;
         player_y   <= '0;
         direction  <= kitchen_pkg::facing_up;
         chop_count <= '0;
      end else if (rise_q[kitchen_pkg::btn_up]) begin
         direction <= kitchen_pkg::facing_up;
         if (player_y != '0) begin
            player_y <= player_y - 8'd1;
         end
      end else if (rise_q[kitchen_pkg::btn_down]) begin
         direction <= kitchen_pkg::facing_down;
         if (player_y < max_y) begin
            player_y <= player_y + 8'd1;
         end
      end else if (rise_q[kitchen_pkg::btn_left]) begin
         direction <= kitchen_pkg::facing_left;
         if (player_x != '0) begin
            player_x <= player_x - 8'd1;
         end
      end else if (rise_q[kitchen_pkg::btn_right]) begin
         direction <= kitchen_pkg::facing_right;
         if (player_x < max_x) begin
            player_x <= player_x + 8'd1;
         end
      end else if (rise_q[kitchen_pkg::btn_chop]) begin
         if (!carry) begin   // hands full, no chopping
            chop_count <= chop_count + 8'd1;
         end
      end
   end

   ////////////////////
   // display word
   ////////////////////

   // digits 7..0: chops, chops, 0, dir, x, x, y, y
   assign status_word = {
      chop_count,
      4'h0,
      2'b00, direction,
      player_x,
      player_y
   };

   // the player never leaves the kitchen
   x_in_grid_a : assert property (
      @(posedge clk_in) disable iff (reset_in)
      player_x <= max_x
   );

   y_in_grid_a : assert property (
      @(posedge clk_in) disable iff (reset_in)
      player_y <= max_y
   );

endmodule

// File: src/player_panel_top.sv
`timescale 1ns/1ps

module player_panel_top #(
   parameter int debounce_cycles = kitchen_pkg::default_debounce_cycles,
   parameter int scan_cycles     = kitchen_pkg::default_scan_cycles
) (
   input  logic                     clk_in,
   input  logic                     reset_in,
   input  kitchen_pkg::button_vec_t btn_raw,
   input  logic                     carry_raw,
   output kitchen_pkg::grid_coord_t player_x,
   output kitchen_pkg::grid_coord_t player_y,
   output kitchen_pkg::direction_t  direction,
   output kitchen_pkg::chop_count_t chop_count,
   output logic [6:0]               cat_out,
   output logic [7:0]               an_out
);

   kitchen_pkg::button_vec_t  btn_sync;
   kitchen_pkg::button_vec_t  btn_clean;
   logic                      carry_sync;   // switch, not debounced
   kitchen_pkg::status_word_t status_word;

   ////////////////////
   // input path
   ////////////////////

   button_sync sync0 (
      .clk_in     (clk_in),
      .reset_in   (reset_in),
      .btn_raw    (btn_raw),
      .carry_raw  (carry_raw),
      .btn_sync   (btn_sync),
      .carry_sync (carry_sync)
   );

   // one debouncer per button
   for (genvar i = 0; i < kitchen_pkg::num_buttons; i++) begin : debounce_gen
      debounce #(
         .debounce_cycles (debounce_cycles)
      ) db (
         .clk_in   (clk_in),
         .reset_in (reset_in),
         .noisy    (btn_sync[i]),
         .clean    (btn_clean[i])
      );
   end

   ////////////////////
   // player and display
   ////////////////////

   player_mover mover0 (
      .clk_in      (clk_in),
      .reset_in    (reset_in),
      .btn_clean   (btn_clean),
      .carry       (carry_sync),
      .player_x    (player_x),
      .player_y    (player_y),
      .direction   (direction),
      .chop_count  (chop_count),
      .status_word (status_word)
   );

   seven_seg_controller #(
      .scan_cycles (scan_cycles)
   ) display0 (
      .clk_in   (clk_in),
      .reset_in (reset_in),
      .val_in   (status_word),
      .cat_out  (cat_out),
      .an_out   (an_out)
   );

endmodule

// File: src/seven_seg_controller.sv
`timescale 1ns/1ps

module seven_seg_controller #(
   parameter int scan_cycles = kitchen_pkg::default_scan_cycles
) (
   input  logic                      clk_in,
   input  logic                      reset_in,
   input  kitchen_pkg::status_word_t val_in,
   output logic [6:0]                cat_out,
   output logic [7:0]                an_out
);

   localparam int cnt_w = (scan_cycles < 1) ? 1 : $clog2(scan_cycles + 1);
   localparam logic [cnt_w-1:0] scan_limit = cnt_w'(scan_cycles);

   logic [7:0]       digit_sel;   // one hot, bit k lights digit k
   logic [cnt_w-1:0] scan_count;
   logic [3:0]       nibble;      // hex value of the lit digit
   logic [6:0]       seg;         // g..a, high means lit

   ////////////////////
   // digit scan
   ////////////////////

   always_ff @(posedge clk_in) begin
      if (reset_in) begin
         digit_sel  <= 8'b0000_0001;
         scan_count <= '0;
      end else if (scan_count == scan_limit) begin
         scan_count <= '0;
         digit_sel  <= {digit_sel[6:0], digit_sel[7]};   // rotate to next digit
      end else begin
         scan_count <= scan_count + 1'b1;
      end
   end

   always_comb begin
      case (digit_sel)
         8'b0000_0001: nibble = val_in[3:0];
         8'b0000_0010: nibble = val_in[7:4];
         8'b0000_0100: nibble = val_in[11:8];
         8'b0000_1000: nibble = val_in[15:12];
         8'b0001_0000: nibble = val_in[19:16];
         8'b0010_0000: nibble = val_in[23:20];
         8'b0100_0000: nibble = val_in[27:24];
         8'b1000_0000: nibble = val_in[31:28];
         default:      nibble = val_in[3:0];
      endcase
   end

   ////////////////////
   // hex decode
   ////////////////////

   always_comb begin
      case (nibble)
         4'h0:    seg = 7'b011_1111;
         4'h1:    seg = 7'b000_0110;
         4'h2:    seg = 7'b101_1011;
         4'h3:    seg = 7'b100_1111;
         4'h4:    seg = 7'b110_0110;
         4'h5:    seg = 7'b110_1101;
         4'h6:    seg = 7'b111_1101;
         4'h7:    seg = 7'b000_0111;
         4'h8:    seg = 7'b111_1111;
         4'h9:    seg = 7'b110_1111;
         4'ha:    seg = 7'b111_0111;
         4'hb:    seg = 7'b111_1100;
         4'hc:    seg = 7'b011_1001;
         4'hd:    seg = 7'b101_1110;
         4'he:    seg = 7'b111_1001;
         default: seg = 7'b111_0001;   // f
      endcase
   end

   // common anode, everything active low
   assign cat_out = ~seg;
   assign an_out  = ~digit_sel;

   one_digit_lit_a : assert property (
      @(posedge clk_in) disable iff (reset_in)
      $onehot(~an_out)
   );

endmodule
